// File: bench/mdu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_checker import mdu_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  instr_t instr,
   input  logic   credit,
   input  logic   illegal,
   input  wb_t    wb,
   output int     error_count,
   output int     pending,
   output int     illegal_words,
   output int     illegal_pulses
);

   // architectural register model, x0 never written
   logic [31:0] model [32];
   // legal words accepted but not yet written back
   logic [31:0] words [$];

   int n_err     = 0;
   int n_ill_in  = 0;
   int n_ill_out = 0;

   assign error_count    = n_err;
   assign illegal_words  = n_ill_in;
   assign illegal_pulses = n_ill_out;

   // R-type M ops, addi and lui only
   function automatic logic is_legal(input logic [31:0] w);
      case (w[6:0])
         7'b0110011: return w[31:25] == 7'b0000001;
         7'b0010011: return w[14:12] == 3'b000;
         7'b0110111: return 1'b1;
         default:    return 1'b0;
      endcase
   endfunction

   // result of one legal word from the model registers
   function automatic logic [31:0] predict(input logic [31:0] w);
      logic [31:0] a;
      logic [31:0] b;
      logic [63:0] ea;
      logic [63:0] eb;
      logic [63:0] p;
      int          sa;
      int          sb;
      logic        ovf;
      a   = model[w[19:15]];
      b   = model[w[24:20]];
      sa  = a;
      sb  = b;
      ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
      if (w[6:0] == 7'b0110111) return {w[31:12], 12'h000};
      if (w[6:0] == 7'b0010011) return a + {{20{w[31]}}, w[31:20]};
      // mulh and mulhsu sign extend rs1, only mulh extends rs2
      ea = (w[14:12] == 3'b001 || w[14:12] == 3'b010) ? {{32{a[31]}}, a} : {32'h0, a};
      eb = (w[14:12] == 3'b001) ? {{32{b[31]}}, b} : {32'h0, b};
      p  = ea * eb;
      case (w[14:12])
         3'b000:                 return p[31:0];
         3'b001, 3'b010, 3'b011: return p[63:32];
         3'b100: begin
            if (b == 32'h0) return 32'hffff_ffff;
            if (ovf) return a;
            return sa / sb;
         end
         3'b101: begin
            if (b == 32'h0) return 32'hffff_ffff;
            return a / b;
         end
         3'b110: begin
            if (b == 32'h0) return a;
            if (ovf) return 32'h0;
            return sa % sb;
         end
         default: begin
            if (b == 32'h0) return a;
            return a % b;
         end
      endcase
   endfunction

   // oldest pending word must match this writeback
   task automatic check_wb();
      logic [31:0] w;
      logic [31:0] exp_data;
      if (words.size() == 0) begin
         n_err++;
         $display("Writeback to x%0d at %0t with no instruction outstanding", wb.rd, $time);
         return;
      end
      w        = words.pop_front();
      exp_data = predict(w);
      if (wb.rd != w[11:7]) begin
         n_err++;
         $display("Mismatch at %0t: wb.rd expected %0d actual %0d", $time, w[11:7], wb.rd);
      end
      if (wb.data != exp_data) begin
         n_err++;
         $display("Mismatch at %0t: wb.data expected %08h actual %08h",
                  $time, exp_data, wb.data);
      end
      if (w[11:7] != 5'd0) model[w[11:7]] = exp_data;
   endtask

   // sample away from the rising edge
   always @(negedge clk) begin
      if (!rst_n) begin
         words.delete();
         for (int i = 0; i < 32; i++) model[i] = '0;
         // outputs stay quiet in reset
         if (credit || illegal || wb.valid) begin
            n_err++;
            $display("Credit, illegal or writeback active during reset at %0t", $time);
         end
      end else begin
         if (instr.valid) begin
            if (is_legal(instr.word)) words.push_back(instr.word);
            else n_ill_in++;
         end
         if (illegal) n_ill_out++;
         if (wb.valid) check_wb();
      end
      pending = words.size();
   end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int HALF_PERIOD = 20
) (
   output logic clk
);

   initial clk = 1'b0;

   // 40 ns period
   always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// File: bench/tb_mdu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_params.svh"

module tb_mdu import mdu_pkg::*; ();

   localparam int N_LOADS        = 2 * (`MDU_NREGS - 1);
   localparam int N_DIRECTED     = 8;
   localparam int N_RANDOM       = 400;
   localparam int N_WORDS        = N_LOADS + N_DIRECTED + N_RANDOM;
   localparam int TIMEOUT_CYCLES = N_WORDS * 40 + 1000;

   logic   clk;
   logic   rst_n;
   instr_t instr;
   logic   credit;
   logic   illegal;
   wb_t    wb;

   int         seed = 34283;
   int         sent;
   int         returned;
   int         bench_errors;
   int         chk_errors;
   int         chk_pending;
   int         chk_ill_words;
   int         chk_ill_pulses;
   logic [4:0] last_rd;

   tb_clock u_clock (.clk(clk));

   mdu_core u_mdu_core (
      .clk(clk), .rst_n(rst_n), .instr(instr), .credit(credit), .illegal(illegal), .wb(wb)
   );

   mdu_checker u_checker (
      .clk(clk), .rst_n(rst_n), .instr(instr), .credit(credit), .illegal(illegal), .wb(wb),
      .error_count(chk_errors), .pending(chk_pending),
      .illegal_words(chk_ill_words), .illegal_pulses(chk_ill_pulses)
   );

   // credits handed back by the core
   always @(negedge clk) begin
      if (!rst_n) returned = 0;
      else if (credit) returned++;
   end

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // x1..x4 hold corner values, never overwritten
   function automatic logic [4:0] pick_rd();
      return (rand_below(16) == 0) ? 5'd0 : 5'(5 + rand_below(27));
   endfunction

   function automatic logic [4:0] pick_rs();
      return (rand_below(4) == 0) ? 5'(rand_below(5)) : 5'(rand_below(32));
   endfunction

   function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
      return {7'b0000001, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
      return {imm, rs1, 3'b000, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] make_illegal();
      logic [31:0] r;
      r = $random(seed);
      case (rand_below(3))
         // base add, slti, custom-0
         0:       return {7'b0000000, r[24:7], 7'b0110011};
         1:       return {r[31:15], 3'b010, r[11:7], 7'b0010011};
         default: return {r[31:7], 7'b0001011};
      endcase
   endfunction

   // hold off until a credit is free
   task automatic send_word(input logic [31:0] w);
      @(posedge clk);
      while (sent - returned >= `MDU_QDEPTH) begin
         instr <= '0;
         @(posedge clk);
      end
      instr <= '{valid: 1'b1, word: w};
      sent++;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         instr <= '0;
      end
   endtask

   // lui takes the rounded upper part, addi adds the sign extended low 12 bits
   task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] hi;
      hi = v + 32'h800;
      send_word(enc_lui(rd, hi[31:12]));
      send_word(enc_addi(rd, rd, v[11:0]));
   endtask

   initial begin
      logic [31:0] v;
      logic [31:0] w;
      logic [4:0]  rs1;
      rst_n        <= 1'b0;
      instr        <= '0;
      sent         = 0;
      bench_errors = 0;
      last_rd      = 5'd5;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      for (int r = 1; r < `MDU_NREGS; r++) begin
         case (r)
            1:       v = 32'h0;
            2:       v = 32'hffff_ffff;
            3:       v = 32'h8000_0000;
            4:       v = 32'h1;
            default: v = $random(seed);
         endcase
         load_reg(5'(r), v);
      end
      // signed overflow, divide by zero, extreme products
      send_word(enc_r(3'b100, 5'd5, 5'd3, 5'd2));
      send_word(enc_r(3'b110, 5'd6, 5'd3, 5'd2));
      send_word(enc_r(3'b101, 5'd7, 5'd3, 5'd1));
      send_word(enc_r(3'b111, 5'd8, 5'd3, 5'd1));
      send_word(enc_r(3'b100, 5'd9, 5'd2, 5'd1));
      send_word(enc_r(3'b110, 5'd10, 5'd2, 5'd1));
      send_word(enc_r(3'b001, 5'd11, 5'd3, 5'd3));
      send_word(enc_r(3'b010, 5'd12, 5'd2, 5'd3));
      for (int i = 0; i < N_RANDOM; i++) begin
         // often chain on the last destination
         rs1 = (rand_below(4) == 0) ? last_rd : pick_rs();
         case (rand_below(16))
            0:       w = make_illegal();
            1:       w = enc_addi(pick_rd(), rs1, 12'(rand_below(4096)));
            default: w = enc_r(3'(rand_below(8)), pick_rd(), rs1, pick_rs());
         endcase
         last_rd = w[11:7];
         send_word(w);
         if (rand_below(4) == 0) idle_cycles(1 + rand_below(3));
      end
      idle_cycles(1);
      // drain the results, then give stray or late credits time to show
      while (chk_pending != 0) @(posedge clk);
      repeat (10) @(posedge clk);
      if (`MDU_QDEPTH - sent + returned != `MDU_QDEPTH) begin
         bench_errors++;
         $display("Sender holds %0d credits after the run instead of %0d",
                  `MDU_QDEPTH - sent + returned, `MDU_QDEPTH);
      end
      if (chk_ill_words != chk_ill_pulses) begin
         bench_errors++;
         $display("%0d illegal words sent but illegal pulsed %0d times",
                  chk_ill_words, chk_ill_pulses);
      end
      $display("errors: checker %0d, bench %0d; words sent %0d, illegal %0d",
               chk_errors, bench_errors, sent, chk_ill_words);
      if (chk_errors + bench_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Run timed out after %0d cycles with %0d words outstanding",
               TIMEOUT_CYCLES, sent - returned);
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: design/mdu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_params.svh"

module mdu_core import mdu_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  instr_t instr,
   output logic   credit,
   output logic   illegal,
   output wb_t    wb
);

   localparam int PTR_W = $clog2(`MDU_QDEPTH);
   localparam int CNT_W = $clog2(`MDU_QDEPTH + 1);

   // instruction queue
   logic [31:0]          q_mem [`MDU_QDEPTH];
   logic [PTR_W-1:0]     q_head;
   logic [PTR_W-1:0]     q_tail;
   logic [CNT_W-1:0]     q_count;
   logic                 q_valid;

   dec_op_t              dec;
   logic [`MDU_XLEN-1:0] rd1;
   logic [`MDU_XLEN-1:0] rd2;
   logic [`MDU_NREGS-1:0] sb;

   logic                 is_div;
   logic                 uses_imm;
   logic                 hazard;
   logic                 issue;
   logic                 drop;
   logic                 pop;
   exec_req_t            req;
   wb_t                  mul_wb;
   wb_t                  div_wb;
   logic                 mul_busy;
   logic                 div_busy;

   assign q_valid = (q_count != '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q_head  <= '0;
         q_tail  <= '0;
         q_count <= '0;
         credit  <= 1'b0;
         illegal <= 1'b0;
         sb      <= '0;
      end else begin
         if (instr.valid) begin
            q_tail <= (q_tail == PTR_W'(`MDU_QDEPTH - 1)) ? '0 : q_tail + 1'b1;
         end
         if (pop) begin
            q_head <= (q_head == PTR_W'(`MDU_QDEPTH - 1)) ? '0 : q_head + 1'b1;
         end
         case ({instr.valid, pop})
            2'b10:   q_count <= q_count + 1'b1;
            2'b01:   q_count <= q_count - 1'b1;
            default: q_count <= q_count;
         endcase
         // slot freed this cycle, hand the credit back next
         credit  <= pop;
         illegal <= drop;
         // writeback clears, issue sets, never the same rd
         sb <= (sb & ~({{(`MDU_NREGS-1){1'b0}}, wb.valid} << wb.rd))
             | ({{(`MDU_NREGS-1){1'b0}}, issue && (dec.rd != 5'd0)} << dec.rd);
      end
   end

   always_ff @(posedge clk) begin
      if (instr.valid) begin
         q_mem[q_tail] <= instr.word;
      end
   end

   mdu_decode u_decode (.instr_word(q_mem[q_head]), .dec(dec));

   mdu_regfile u_regfile (
      .clk(clk), .rst_n(rst_n), .rs1(dec.rs1), .rs2(dec.rs2),
      .we(wb.valid), .wr_addr(wb.rd), .wr_data(wb.data), .rd1(rd1), .rd2(rd2)
   );

   assign is_div   = (dec.op == op_div) || (dec.op == op_divu)
                  || (dec.op == op_rem) || (dec.op == op_remu);
   assign uses_imm = (dec.op == op_addi) || (dec.op == op_lui);

   // pending rd too, so an older write cannot clear a newer claim
   assign hazard = sb[dec.rs1] | sb[dec.rs2] | sb[dec.rd];
   assign drop   = q_valid & dec.illegal;
   assign issue  = q_valid & ~dec.illegal & ~hazard & ~div_busy & ~(is_div & mul_busy);
   assign pop    = issue | drop;

   assign req = '{op: dec.op, rd: dec.rd, a: rd1, b: (uses_imm ? dec.imm : rd2)};

   mdu_mul_pipe u_mul (
      .clk(clk), .rst_n(rst_n), .req(req), .req_valid(issue & ~is_div),
      .wb(mul_wb), .busy(mul_busy)
   );

   mdu_divider u_div (
      .clk(clk), .rst_n(rst_n), .req(req), .req_valid(issue & is_div),
      .wb(div_wb), .busy(div_busy)
   );

   // issue rules keep the two units apart
   assign wb = mul_wb.valid ? mul_wb : div_wb;

   // sender must hold a credit
   a_no_push_full: assert property (
      @(posedge clk) disable iff (!rst_n)
      instr.valid |-> (q_count < CNT_W'(`MDU_QDEPTH))
   ) else $error("push into full instruction queue");

   a_wb_exclusive: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(mul_wb.valid && div_wb.valid)
   ) else $error("multiplier and divider wrote back together");

endmodule

`default_nettype wire

// File: design/mdu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_params.svh"

module mdu_decode import mdu_pkg::*; (
   input  logic [31:0] instr_word,
   output dec_op_t     dec
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = instr_word[6:0];
   assign funct3 = instr_word[14:12];
   assign funct7 = instr_word[31:25];

   always_comb begin
      // defaults, anything unmatched stays illegal
      dec.op      = op_addi;
      dec.rd      = instr_word[11:7];
      dec.rs1     = instr_word[19:15];
      dec.rs2     = instr_word[24:20];
      dec.imm     = '0;
      dec.illegal = 1'b1;
      case (opcode)
         // R-type, M extension only
         7'b0110011: begin
            if (funct7 == 7'b0000001) begin
               dec.illegal = 1'b0;
               case (funct3)
                  3'b000:  dec.op = op_mul;
                  3'b001:  dec.op = op_mulh;
                  3'b010:  dec.op = op_mulhsu;
                  3'b011:  dec.op = op_mulhu;
                  3'b100:  dec.op = op_div;
                  3'b101:  dec.op = op_divu;
                  3'b110:  dec.op = op_rem;
                  default: dec.op = op_remu;
               endcase
            end
         end
         // addi, rs2 field belongs to the immediate
         7'b0010011: begin
            if (funct3 == 3'b000) begin
               dec.illegal = 1'b0;
               dec.op      = op_addi;
               dec.rs2     = 5'd0;
               dec.imm     = {{(`MDU_XLEN-12){instr_word[31]}}, instr_word[31:20]};
            end
         end
         // lui reads no register
         7'b0110111: begin
            dec.illegal = 1'b0;
            dec.op      = op_lui;
            dec.rs1     = 5'd0;
            dec.rs2     = 5'd0;
            dec.imm     = {instr_word[31:12], 12'b0};
         end
         default: dec.illegal = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

// File: design/mdu_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_params.svh"

module mdu_divider import mdu_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  exec_req_t req,
   input  logic      req_valid,
   output wb_t       wb,
   output logic      busy
);

   localparam int CNT_W = $clog2(`MDU_DIV_STEPS);

   div_state_e           state;
   logic [CNT_W-1:0]     count;

   // request side helpers
   logic                 req_signed;
   logic                 neg_a;
   logic                 neg_b;
   logic [`MDU_XLEN-1:0] abs_a;
   logic [`MDU_XLEN-1:0] abs_b;

   // working registers
   logic [`MDU_XLEN-1:0] quo;
   logic [`MDU_XLEN-1:0] rem;
   logic [`MDU_XLEN-1:0] dvs;
   logic [`MDU_XLEN-1:0] orig_a;
   logic [4:0]           rd_q;
   logic                 want_rem;
   logic                 neg_q;
   logic                 neg_r;
   logic                 div_zero;

   // one restoring step
   logic [`MDU_XLEN:0]   shifted;
   logic [`MDU_XLEN:0]   diff;

   // fixed up results
   logic [`MDU_XLEN-1:0] q_fix;
   logic [`MDU_XLEN-1:0] r_fix;

   assign req_signed = (req.op == op_div) || (req.op == op_rem);
   assign neg_a      = req_signed & req.a[`MDU_XLEN-1];
   assign neg_b      = req_signed & req.b[`MDU_XLEN-1];
   assign abs_a      = neg_a ? -req.a : req.a;
   assign abs_b      = neg_b ? -req.b : req.b;

   // bring down the next dividend bit, try the subtract
   assign shifted = {rem, quo[`MDU_XLEN-1]};
   assign diff    = shifted - {1'b0, dvs};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= div_idle;
         count <= '0;
      end else begin
         case (state)
            div_idle: begin
               count <= '0;
               if (req_valid) begin
                  // divide by zero skips the iterations
                  state <= (req.b == '0) ? div_done : div_run;
               end
            end
            div_run: begin
               count <= count + 1'b1;
               if (count == CNT_W'(`MDU_DIV_STEPS - 1)) begin
                  state <= div_done;
               end
            end
            default: state <= div_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == div_idle) begin
         quo      <= abs_a;
         rem      <= '0;
         dvs      <= abs_b;
         orig_a   <= req.a;
         rd_q     <= req.rd;
         want_rem <= (req.op == op_rem) || (req.op == op_remu);
         neg_q    <= neg_a ^ neg_b;
         neg_r    <= neg_a;
         div_zero <= (req.b == '0);
      end else if (state == div_run) begin
         // msb of diff clear means the subtract fit
         if (!diff[`MDU_XLEN]) begin
            rem <= diff[`MDU_XLEN-1:0];
            quo <= {quo[`MDU_XLEN-2:0], 1'b1};
         end else begin
            rem <= shifted[`MDU_XLEN-1:0];
            quo <= {quo[`MDU_XLEN-2:0], 1'b0};
         end
      end
   end

   // quotient sign from both operands, remainder follows the dividend
   // 0x80000000 / -1 yields the dividend with rem 0 without a special case
   assign q_fix = neg_q ? -quo : quo;
   assign r_fix = neg_r ? -rem : rem;

   assign wb.valid = (state == div_done);
   assign wb.rd    = rd_q;
   assign wb.data  = div_zero ? (want_rem ? orig_a : '1) : (want_rem ? r_fix : q_fix);

   assign busy = (state != div_idle);

   // issue logic must wait for idle
   a_no_req_busy: assert property (
      @(posedge clk) disable iff (!rst_n)
      req_valid |-> !busy
   ) else $error("divider request while busy");

endmodule

`default_nettype wire

// File: design/mdu_mul_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_params.svh"

module mdu_mul_pipe import mdu_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  exec_req_t req,
   input  logic      req_valid,
   output wb_t       wb,
   output logic      busy
);

   logic                     a_signed;
   logic                     b_signed;
   logic signed [`MDU_XLEN:0]     a_ext;
   logic signed [`MDU_XLEN:0]     b_ext;
   logic signed [2*`MDU_XLEN+1:0] full;

   // stage one
   logic                     s1_valid;
   mdu_op_e                  s1_op;
   logic [4:0]               s1_rd;
   logic [2*`MDU_XLEN-1:0]   s1_prod;
   logic [`MDU_XLEN-1:0]     s1_a;
   logic [`MDU_XLEN-1:0]     s1_b;

   // stage two, drives wb
   logic                     s2_valid;
   logic [4:0]               s2_rd;
   logic [`MDU_XLEN-1:0]     s2_data;
   logic [`MDU_XLEN-1:0]     s2_next;

   // mulhsu: rs1 signed, rs2 unsigned
   assign a_signed = (req.op == op_mulh) || (req.op == op_mulhsu);
   assign b_signed = (req.op == op_mulh);

   // one extra bit so a single signed multiply covers every variant
   assign a_ext = {a_signed & req.a[`MDU_XLEN-1], req.a};
   assign b_ext = {b_signed & req.b[`MDU_XLEN-1], req.b};
   assign full  = a_ext * b_ext;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else begin
         s1_valid <= req_valid;
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      s1_op   <= req.op;
      s1_rd   <= req.rd;
      s1_prod <= full[2*`MDU_XLEN-1:0];
      s1_a    <= req.a;
      s1_b    <= req.b;
      s2_rd   <= s1_rd;
      s2_data <= s2_next;
   end

   // result select for stage two
   always_comb begin
      case (s1_op)
         op_addi: s2_next = s1_a + s1_b;
         op_lui:  s2_next = s1_b;
         op_mul:  s2_next = s1_prod[`MDU_XLEN-1:0];
         default: s2_next = s1_prod[2*`MDU_XLEN-1:`MDU_XLEN];
      endcase
   end

   assign wb   = '{valid: s2_valid, rd: s2_rd, data: s2_data};
   // two ops may be in flight
   assign busy = s1_valid | s2_valid;

endmodule

`default_nettype wire

// File: design/mdu_params.svh
`ifndef MDU_PARAMS_SVH
`define MDU_PARAMS_SVH

// datapath width of the rv32 slice
`define MDU_XLEN 32

// architectural registers, x0 included
`define MDU_NREGS 32

// instruction queue slots
// the sender starts with one credit per slot
`define MDU_QDEPTH 4

// restoring divider iterations, one quotient bit each
`define MDU_DIV_STEPS 32

`endif

// File: design/mdu_pkg.sv
`default_nettype none

`include "mdu_params.svh"

package mdu_pkg;

   // ops handled by this slice
   // addi/lui only there to load operands
   typedef enum logic [3:0] {
      op_addi, op_lui,
      op_mul, op_mulh, op_mulhsu, op_mulhu,
      op_div, op_divu, op_rem, op_remu
   } mdu_op_e;

   // divider sequencing
   typedef enum logic [1:0] {div_idle, div_run, div_done} div_state_e;

   // word on the credit port
   typedef struct packed {
      logic        valid;
      logic [31:0] word;
   } instr_t;

   // decoder output, illegal means drop at the head
   typedef struct packed {
      mdu_op_e               op;
      logic [4:0]            rd;
      logic [4:0]            rs1;
      logic [4:0]            rs2;
      logic [`MDU_XLEN-1:0]  imm;
      logic                  illegal;
   } dec_op_t;

   // issued op with operands already read
   typedef struct packed {
      mdu_op_e               op;
      logic [4:0]            rd;
      logic [`MDU_XLEN-1:0]  a;
      logic [`MDU_XLEN-1:0]  b;
   } exec_req_t;

   // result towards the regfile
   typedef struct packed {
      logic                  valid;
      logic [4:0]            rd;
      logic [`MDU_XLEN-1:0]  data;
   } wb_t;

endpackage

`default_nettype wire

// File: design/mdu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_params.svh"

module mdu_regfile (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [4:0]           rs1,
   input  logic [4:0]           rs2,
   input  logic                 we,
   input  logic [4:0]           wr_addr,
   input  logic [`MDU_XLEN-1:0] wr_data,
   output logic [`MDU_XLEN-1:0] rd1,
   output logic [`MDU_XLEN-1:0] rd2
);

   logic [`MDU_XLEN-1:0] regs [`MDU_NREGS];

   // whole file cleared on reset
   // x0 is never written afterwards
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `MDU_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (wr_addr != 5'd0)) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // combinational read ports
   // a write lands on the edge, readers see it next cycle
   assign rd1 = regs[rs1];
   assign rd2 = regs[rs2];

   // x0 must read zero even after writebacks aimed at it
   a_x0_zero: assert property (
      @(posedge clk) disable iff (!rst_n)
      (rs1 == 5'd0) |-> (rd1 == '0)
   ) else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build with Verilator, run, and judge the log
verilator --binary --timing --assert -j 0 --top-module tb_mdu -f tb.f -o tb_mdu_sim \
   > build.log 2>&1 \
   && ./obj_dir/tb_mdu_sim > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

// File: tb.f
+incdir+design
design/mdu_pkg.sv
design/mdu_decode.sv
design/mdu_regfile.sv
design/mdu_mul_pipe.sv
design/mdu_divider.sv
design/mdu_core.sv
bench/tb_clock.sv
bench/mdu_checker.sv
bench/tb_mdu.sv
